//--- vlog.f
+incdir+tests
verilog/decodePkg.sv
verilog/instrDecoder.sv
verilog/operandBypass.sv
verilog/branchUnit.sv
verilog/idExLatch.sv
verilog/decodeStage.sv
tests/decodeStageTb.sv

//--- run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f vlog.f --top-module decodeStageTb

status=0
./obj_dir/VdecodeStageTb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "sim failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation OK"

//--- tests/decodeModel.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expected values, written by expectDecode
logic     expRd1En;
logic     expRd2En;
regAddr_t expRd1Addr;
regAddr_t expRd2Addr;
logic     expStall;
logic     expJump;
word_t    expTarget;
word_t    expOp1;
word_t    expOp2;
aluOp_t   expAluOp;
logic     expWrEn;
regAddr_t expWrAddr;

function automatic word_t signExtend(input word_t v, input int bits);
  word_t shifted;
  shifted = v << (16 - bits);
  return word_t'($signed(shifted) >>> (16 - bits));
endfunction

// Priority for one port: execute, then memory, then the register file
function automatic word_t forwardedValue(input logic en, input regAddr_t addr,
                                         output logic hazard);
  hazard = 1'b0;
  if (!en) begin
    return '0;
  end
  if (exWrAddr == addr && exAluOp == aluLw) begin
    hazard = 1'b1;
    return '0;
  end
  if (exWrEn && exWrAddr == addr) begin
    return exWrData;
  end
  if (memWrEn && memWrAddr == addr) begin
    return memWrData;
  end
  return regFile[addr];
endfunction

// Kind numbers follow the instruction list used by the stimulus
function automatic void expectDecode(input int kind, input word_t inst, input word_t pc,
                                     input logic slot);
  regAddr_t    rx;
  regAddr_t    ry;
  regAddr_t    rz;
  word_t       imm;
  opnd1Src_t   s1;
  opnd2Src_t   s2;
  branchKind_t br;
  word_t       d1;
  word_t       d2;
  logic        h1;
  logic        h2;
  logic        taken;
  rx         = {1'b0, inst[10:8]};
  ry         = {1'b0, inst[7:5]};
  rz         = {1'b0, inst[4:2]};
  expRd1En   = 1'b0;
  expRd2En   = 1'b0;
  expRd1Addr = '0;
  expRd2Addr = '0;
  expAluOp   = aluNop;
  expWrEn    = 1'b0;
  expWrAddr  = '0;
  s1         = src1Zero;
  s2         = src2Zero;
  imm        = '0;
  br         = brNone;
  case (kind)
    1: begin
      imm = signExtend(inst, 11);
      br  = brAlways;
    end
    // BEQZ, BNEZ, BTEQZ
    2, 3, 4: begin
      expRd1En   = 1'b1;
      expRd1Addr = (kind == 4) ? regT : rx;
      imm        = signExtend(inst, 8);
      br         = (kind == 3) ? brIfNonzero : brIfZero;
    end
    5, 6: begin
      expRd1En   = 1'b1;
      expRd1Addr = ry;
      s1         = src1Port;
      s2         = src2Imm;
      imm        = {13'b0, inst[4:2]};
      expAluOp   = (kind == 5) ? aluSll : aluSra;
      expWrEn    = 1'b1;
      expWrAddr  = rx;
    end
    // Register plus immediate, loads included
    7, 8, 9, 10, 12, 13, 14: begin
      expRd1En   = 1'b1;
      expRd1Addr = (kind == 9 || kind == 14) ? regSp : rx;
      s1         = src1Port;
      s2         = src2Imm;
      imm        = signExtend(inst, (kind == 7) ? 4 : (kind == 13) ? 5 : 8);
      expAluOp   = (kind == 10) ? aluSlt : (kind == 12) ? aluCmp :
                   (kind >= 13) ? aluLw : aluAdd;
      expWrEn    = 1'b1;
      case (kind)
        7, 13:   expWrAddr = ry;
        9:       expWrAddr = regSp;
        10, 12:  expWrAddr = regT;
        default: expWrAddr = rx;
      endcase
    end
    11: begin
      s1        = src1ZeroImm8;
      imm       = {8'b0, inst[7:0]};
      expAluOp  = aluOr;
      expWrEn   = 1'b1;
      expWrAddr = rx;
    end
    // Stores never write a register
    15, 16: begin
      expRd1En   = 1'b1;
      expRd2En   = 1'b1;
      expRd1Addr = (kind == 15) ? rx : regSp;
      expRd2Addr = (kind == 15) ? ry : rx;
      s1         = src1PortImm;
      s2         = src2Port;
      imm        = signExtend(inst, (kind == 15) ? 5 : 8);
      expAluOp   = aluSw;
    end
    17, 18, 19, 20: begin
      expRd1En   = 1'b1;
      expRd2En   = 1'b1;
      expRd1Addr = rx;
      expRd2Addr = ry;
      s1         = src1Port;
      s2         = src2Port;
      case (kind)
        17:      expAluOp = aluAdd;
        18:      expAluOp = aluSub;
        19:      expAluOp = aluAnd;
        default: expAluOp = aluOr;
      endcase
      expWrEn    = 1'b1;
      expWrAddr  = (kind <= 18) ? rz : rx;
    end
    // NOT and MTSP
    21, 23: begin
      expRd1En   = 1'b1;
      expRd1Addr = ry;
      s1         = src1Port;
      expAluOp   = (kind == 21) ? aluNot : aluOr;
      expWrEn    = 1'b1;
      expWrAddr  = (kind == 21) ? rx : regSp;
    end
    22: begin
      s1        = src1InstAddr;
      expAluOp  = aluOr;
      expWrEn   = 1'b1;
      expWrAddr = rx;
    end
    24, 25, 26: begin
      expRd1En   = 1'b1;
      expRd1Addr = (kind == 26) ? regRa : rx;
      br         = brRegister;
      if (kind == 25) begin
        s1        = src1InstAddr;
        s2        = src2PcStep;
        expAluOp  = aluAdd;
        expWrEn   = 1'b1;
        expWrAddr = regRa;
      end
    end
    default: begin
    end
  endcase

  d1       = forwardedValue(expRd1En, expRd1Addr, h1);
  d2       = forwardedValue(expRd2En, expRd2Addr, h2);
  expStall = h1 | h2;

  taken     = (br == brAlways) || (br == brRegister) ||
              (br == brIfZero && d1 == '0) || (br == brIfNonzero && d1 != '0);
  expJump   = taken && !slot && !expStall;
  expTarget = !expJump ? '0 : (br == brRegister) ? d1 : pc + imm;

  case (s1)
    src1Port:     expOp1 = d1;
    src1ZeroImm8: expOp1 = {8'b0, imm[7:0]};
    src1InstAddr: expOp1 = pc;
    src1PortImm:  expOp1 = d1 + imm;
    default:      expOp1 = '0;
  endcase
  case (s2)
    src2Port:   expOp2 = d2;
    src2Imm:    expOp2 = imm;
    src2PcStep: expOp2 = pcStep;
    default:    expOp2 = '0;
  endcase

  // A stalled instruction leaves a bubble behind
  if (expStall) begin
    expOp1    = '0;
    expOp2    = '0;
    expAluOp  = aluNop;
    expWrEn   = 1'b0;
    expWrAddr = '0;
  end
endfunction

`endif

//--- tests/decodeStageTb.sv
`timescale 1ns/1ns

module decodeStageTb;
  import decodePkg::*;

  localparam int numTests  = 4000;
  localparam int clkPeriod = 8;
  localparam int timeLimit = (numTests + 20) * clkPeriod + 200;

  logic        clk = 1'b0;
  logic        rstN;
  word_t       instAddr;
  word_t       inst;
  logic        inDelaySlot;
  word_t       reg1Data;
  word_t       reg2Data;
  logic        exWrEn;
  regAddr_t    exWrAddr;
  word_t       exWrData;
  aluOp_t      exAluOp;
  logic        memWrEn;
  regAddr_t    memWrAddr;
  word_t       memWrData;
  logic        reg1RdEn;
  logic        reg2RdEn;
  regAddr_t    reg1Addr;
  regAddr_t    reg2Addr;
  logic        jump;
  word_t       jumpTarget;
  logic        stall;
  word_t       exOperand1;
  word_t       exOperand2;
  aluOp_t      exAluOpQ;
  logic        exWrEnQ;
  regAddr_t    exWrAddrQ;
  word_t       regFile [16];
  logic [31:0] lcgState = 32'd98227;
  int          curKind;
  int          testIdx = 0;
  word_t       pendOp1;
  word_t       pendOp2;
  aluOp_t      pendAluOp;
  logic        pendWrEn;
  regAddr_t    pendWrAddr;

`include "decodeModel.svh"

  always #(clkPeriod / 2) clk = ~clk;

  // Register file answers the read ports combinationally
  assign reg1Data = regFile[reg1Addr];
  assign reg2Data = regFile[reg2Addr];

  decodeStage dut (
    .clk_i(clk),
    .rstN_i(rstN),
    .instAddr_i(instAddr),
    .inst_i(inst),
    .inDelaySlot_i(inDelaySlot),
    .reg1Data_i(reg1Data),
    .reg2Data_i(reg2Data),
    .exWrEn_i(exWrEn),
    .exWrAddr_i(exWrAddr),
    .exWrData_i(exWrData),
    .exAluOp_i(exAluOp),
    .memWrEn_i(memWrEn),
    .memWrAddr_i(memWrAddr),
    .memWrData_i(memWrData),
    .reg1RdEn_o(reg1RdEn),
    .reg2RdEn_o(reg2RdEn),
    .reg1Addr_o(reg1Addr),
    .reg2Addr_o(reg2Addr),
    .jump_o(jump),
    .jumpTarget_o(jumpTarget),
    .stall_o(stall),
    .exOperand1_o(exOperand1),
    .exOperand2_o(exOperand2),
    .exAluOp_o(exAluOpQ),
    .exWrEn_o(exWrEnQ),
    .exWrAddr_o(exWrAddrQ)
  );

  function automatic word_t nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[30:15];
  endfunction

  // One legal encoding per kind with free fields from r
  function automatic word_t legalInst(input int kind, input word_t r);
    case (kind)
      1:       return {opB, r[10:0]};
      2:       return {opBeqz, r[10:0]};
      3:       return {opBnez, r[10:0]};
      4:       return {opSpGroup, functBteqz, r[7:0]};
      5:       return {opShift, r[10:2], functSll};
      6:       return {opShift, r[10:2], functSra};
      7:       return {opAddiu3, r[10:0]};
      8:       return {opAddiu, r[10:0]};
      9:       return {opSpGroup, functAddsp, r[7:0]};
      10:      return {opSlti, r[10:0]};
      11:      return {opLi, r[10:0]};
      12:      return {opCmpi, r[10:0]};
      13:      return {opLw, r[10:0]};
      14:      return {opLwSp, r[10:0]};
      15:      return {opSw, r[10:0]};
      16:      return {opSwSp, r[10:0]};
      17:      return {opAddSub, r[10:2], functAddu};
      18:      return {opAddSub, r[10:2], functSubu};
      19:      return {opLogicJump, r[10:5], functAnd};
      20:      return {opLogicJump, r[10:5], functOr};
      21:      return {opLogicJump, r[10:5], functNot};
      22:      return {opLogicJump, r[10:8], functMfpc};
      23:      return {opSpGroup, functMtsp, r[7:0]};
      24:      return {opLogicJump, r[10:8], functJr};
      25:      return {opLogicJump, r[10:8], functJalr};
      26:      return {opLogicJump, functJrra};
      default: return {opNop, 11'b0};
    endcase
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic checkWord(input string name, input word_t expVal, input word_t actVal);
    if (actVal !== expVal) begin
      abortRun($sformatf("** Error %s: expected %h, actual %h", name, expVal, actVal));
    end
  endtask

  task automatic checkAddr(input string name, input regAddr_t expVal, input regAddr_t actVal);
    if (actVal !== expVal) begin
      abortRun($sformatf("** Error %s: expected %0d, actual %0d", name, expVal, actVal));
    end
  endtask

  task automatic checkAluOp(input string name, input aluOp_t expVal, input aluOp_t actVal);
    if (actVal !== expVal) begin
      abortRun($sformatf("** Error %s: expected %s, actual %s", name, expVal.name(),
                         actVal.name()));
    end
  endtask

  task automatic checkBit(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      abortRun($sformatf("** Error %s: expected %b, actual %b", name, expVal, actVal));
    end
  endtask

  initial begin : stimulus
    int       kind;
    regAddr_t idx;
    word_t    r;
    rstN        = 1'b0;
    instAddr    = '0;
    // LI with a nonzero immediate waits at the input during reset
    inst        = legalInst(11, 16'h05a5);
    curKind     = 11;
    inDelaySlot = 1'b0;
    exWrEn      = 1'b0;
    exWrAddr    = '0;
    exWrData    = '0;
    exAluOp     = aluNop;
    memWrEn     = 1'b0;
    memWrAddr   = '0;
    memWrData   = '0;
    for (int i = 0; i < 16; i++) begin
      regFile[i] = nextRandom();
    end
    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    for (int i = 0; i < numTests; i++) begin
      @(posedge clk);
      kind = nextRandom() % 27;
      curKind     <= kind;
      inst        <= legalInst(kind, nextRandom());
      instAddr    <= nextRandom();
      inDelaySlot <= (nextRandom() % 4 == 0);
      // Few register numbers so that ports, execute and memory often collide
      exWrEn      <= (nextRandom() % 4 != 0);
      exWrAddr    <= regAddr_t'(nextRandom() % 11);
      r = nextRandom();
      exWrData    <= (r[2:0] == 3'b000) ? 16'h0000 : r;
      exAluOp     <= (nextRandom() % 6 == 0) ? aluLw : aluOp_t'(nextRandom() % 10);
      memWrEn     <= (nextRandom() % 4 != 0);
      memWrAddr   <= regAddr_t'(nextRandom() % 11);
      memWrData   <= nextRandom();
      idx = regAddr_t'(nextRandom() % 11);
      r = nextRandom();
      regFile[idx] <= (r[1:0] == 2'b00) ? 16'h0000 : r;
    end
    @(posedge clk);
    @(negedge clk);
    #(clkPeriod / 4);
    $display("sim passed");
    $finish;
  end

  // Combinational outputs now and registered outputs one edge later
  initial begin : compare
    string tag;
    pendOp1    = '0;
    pendOp2    = '0;
    pendAluOp  = aluNop;
    pendWrEn   = 1'b0;
    pendWrAddr = '0;
    forever begin
      @(negedge clk);
      if (!rstN) begin
        checkAluOp("reset exAluOp_o", aluNop, exAluOpQ);
        checkBit("reset exWrEn_o", 1'b0, exWrEnQ);
        checkAddr("reset exWrAddr_o", '0, exWrAddrQ);
        checkWord("reset exOperand1_o", '0, exOperand1);
        checkWord("reset exOperand2_o", '0, exOperand2);
      end else begin
        tag = $sformatf("test %0d", testIdx);
        checkWord({tag, " exOperand1_o"}, pendOp1, exOperand1);
        checkWord({tag, " exOperand2_o"}, pendOp2, exOperand2);
        checkAluOp({tag, " exAluOp_o"}, pendAluOp, exAluOpQ);
        checkBit({tag, " exWrEn_o"}, pendWrEn, exWrEnQ);
        checkAddr({tag, " exWrAddr_o"}, pendWrAddr, exWrAddrQ);
        expectDecode(curKind, inst, instAddr, inDelaySlot);
        checkBit({tag, " reg1RdEn_o"}, expRd1En, reg1RdEn);
        checkBit({tag, " reg2RdEn_o"}, expRd2En, reg2RdEn);
        checkAddr({tag, " reg1Addr_o"}, expRd1Addr, reg1Addr);
        checkAddr({tag, " reg2Addr_o"}, expRd2Addr, reg2Addr);
        checkBit({tag, " stall_o"}, expStall, stall);
        checkBit({tag, " jump_o"}, expJump, jump);
        checkWord({tag, " jumpTarget_o"}, expTarget, jumpTarget);
        pendOp1    = expOp1;
        pendOp2    = expOp2;
        pendAluOp  = expAluOp;
        pendWrEn   = expWrEn;
        pendWrAddr = expWrAddr;
        testIdx++;
      end
    end
  end

  initial begin : watchdog
    #(timeLimit);
    abortRun("Watchdog timeout, the stimulus did not finish in time");
  end

endmodule

//--- verilog/decodeStage.sv
`timescale 1ns/1ns

module decodeStage (
  input  logic                clk_i,
  input  logic                rstN_i,
  input  decodePkg::word_t    instAddr_i,
  input  decodePkg::word_t    inst_i,
  input  logic                inDelaySlot_i,
  input  decodePkg::word_t    reg1Data_i,
  input  decodePkg::word_t    reg2Data_i,
  input  logic                exWrEn_i,
  input  decodePkg::regAddr_t exWrAddr_i,
  input  decodePkg::word_t    exWrData_i,
  input  decodePkg::aluOp_t   exAluOp_i,
  input  logic                memWrEn_i,
  input  decodePkg::regAddr_t memWrAddr_i,
  input  decodePkg::word_t    memWrData_i,
  output logic                reg1RdEn_o,
  output logic                reg2RdEn_o,
  output decodePkg::regAddr_t reg1Addr_o,
  output decodePkg::regAddr_t reg2Addr_o,
  output logic                jump_o,
  output decodePkg::word_t    jumpTarget_o,
  output logic                stall_o,
  output decodePkg::word_t    exOperand1_o,
  output decodePkg::word_t    exOperand2_o,
  output decodePkg::aluOp_t   exAluOp_o,
  output logic                exWrEn_o,
  output decodePkg::regAddr_t exWrAddr_o
);
  import decodePkg::*;

  opnd1Src_t   opnd1Src;
  opnd2Src_t   opnd2Src;
  word_t       imm;
  aluOp_t      aluOp;
  logic        wrEn;
  regAddr_t    wrAddr;
  branchKind_t branch;
  word_t       data1;
  word_t       data2;
  logic        hazard1;
  logic        hazard2;

  instrDecoder decoder (
    .inst_i(inst_i),
    .rd1En_o(reg1RdEn_o),
    .rd2En_o(reg2RdEn_o),
    .rd1Addr_o(reg1Addr_o),
    .rd2Addr_o(reg2Addr_o),
    .opnd1Src_o(opnd1Src),
    .opnd2Src_o(opnd2Src),
    .imm_o(imm),
    .aluOp_o(aluOp),
    .wrEn_o(wrEn),
    .wrAddr_o(wrAddr),
    .branch_o(branch)
  );

  operandBypass port1 (
    .rdEn_i(reg1RdEn_o),
    .rdAddr_i(reg1Addr_o),
    .fileData_i(reg1Data_i),
    .exWrEn_i(exWrEn_i),
    .exWrAddr_i(exWrAddr_i),
    .exWrData_i(exWrData_i),
    .exAluOp_i(exAluOp_i),
    .memWrEn_i(memWrEn_i),
    .memWrAddr_i(memWrAddr_i),
    .memWrData_i(memWrData_i),
    .data_o(data1),
    .loadHazard_o(hazard1)
  );

  operandBypass port2 (
    .rdEn_i(reg2RdEn_o),
    .rdAddr_i(reg2Addr_o),
    .fileData_i(reg2Data_i),
    .exWrEn_i(exWrEn_i),
    .exWrAddr_i(exWrAddr_i),
    .exWrData_i(exWrData_i),
    .exAluOp_i(exAluOp_i),
    .memWrEn_i(memWrEn_i),
    .memWrAddr_i(memWrAddr_i),
    .memWrData_i(memWrData_i),
    .data_o(data2),
    .loadHazard_o(hazard2)
  );

  // Condition uses the forwarded port 1 value
  branchUnit branch0 (
    .branch_i(branch),
    .imm_i(imm),
    .instAddr_i(instAddr_i),
    .opnd1_i(data1),
    .inDelaySlot_i(inDelaySlot_i),
    .stall_i(stall_o),
    .jump_o(jump_o),
    .jumpTarget_o(jumpTarget_o)
  );

  idExLatch latch (
    .clk_i(clk_i),
    .rstN_i(rstN_i),
    .opnd1Src_i(opnd1Src),
    .opnd2Src_i(opnd2Src),
    .imm_i(imm),
    .instAddr_i(instAddr_i),
    .data1_i(data1),
    .data2_i(data2),
    .hazard1_i(hazard1),
    .hazard2_i(hazard2),
    .aluOp_i(aluOp),
    .wrEn_i(wrEn),
    .wrAddr_i(wrAddr),
    .stall_o(stall_o),
    .exOperand1_o(exOperand1_o),
    .exOperand2_o(exOperand2_o),
    .exAluOp_o(exAluOp_o),
    .exWrEn_o(exWrEn_o),
    .exWrAddr_o(exWrAddr_o)
  );

endmodule

//--- verilog/idExLatch.sv
`timescale 1ns/1ns

module idExLatch (
  input  logic                  clk_i,
  input  logic                  rstN_i,
  input  decodePkg::opnd1Src_t  opnd1Src_i,
  input  decodePkg::opnd2Src_t  opnd2Src_i,
  input  decodePkg::word_t      imm_i,
  input  decodePkg::word_t      instAddr_i,
  input  decodePkg::word_t      data1_i,
  input  decodePkg::word_t      data2_i,
  input  logic                  hazard1_i,
  input  logic                  hazard2_i,
  input  decodePkg::aluOp_t     aluOp_i,
  input  logic                  wrEn_i,
  input  decodePkg::regAddr_t   wrAddr_i,
  output logic                  stall_o,
  output decodePkg::word_t      exOperand1_o,
  output decodePkg::word_t      exOperand2_o,
  output decodePkg::aluOp_t     exAluOp_o,
  output logic                  exWrEn_o,
  output decodePkg::regAddr_t   exWrAddr_o
);
  import decodePkg::*;

  word_t operand1;
  word_t operand2;

  assign stall_o = hazard1_i | hazard2_i;

  always_comb begin
    case (opnd1Src_i)
      src1Port:     operand1 = data1_i;
      src1ZeroImm8: operand1 = {8'b0, imm_i[7:0]};
      src1InstAddr: operand1 = instAddr_i;
      src1PortImm:  operand1 = data1_i + imm_i;
      default:      operand1 = '0;
    endcase
  end

  always_comb begin
    case (opnd2Src_i)
      src2Port:   operand2 = data2_i;
      src2Imm:    operand2 = imm_i;
      src2PcStep: operand2 = pcStep;
      default:    operand2 = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      exOperand1_o <= '0;
      exOperand2_o <= '0;
      exAluOp_o    <= aluNop;
      exWrEn_o     <= 1'b0;
      exWrAddr_o   <= '0;
    end else if (stall_o) begin
      // Bubble, the instruction is presented again next cycle
      exOperand1_o <= '0;
      exOperand2_o <= '0;
      exAluOp_o    <= aluNop;
      exWrEn_o     <= 1'b0;
      exWrAddr_o   <= '0;
    end else begin
      exOperand1_o <= operand1;
      exOperand2_o <= operand2;
      exAluOp_o    <= aluOp_i;
      exWrEn_o     <= wrEn_i;
      exWrAddr_o   <= wrAddr_i;
    end
  end

endmodule

//--- verilog/branchUnit.sv
`timescale 1ns/1ns

module branchUnit (
  input  decodePkg::branchKind_t branch_i,
  input  decodePkg::word_t       imm_i,
  input  decodePkg::word_t       instAddr_i,
  input  decodePkg::word_t       opnd1_i,
  input  logic                   inDelaySlot_i,
  input  logic                   stall_i,
  output logic                   jump_o,
  output decodePkg::word_t       jumpTarget_o
);
  import decodePkg::*;

  logic  taken;
  logic  opndZero;
  word_t relTarget;
  word_t target;

  assign opndZero  = (opnd1_i == '0);
  assign relTarget = instAddr_i + imm_i;

  always_comb begin
    taken  = 1'b0;
    target = relTarget;
    case (branch_i)
      brAlways: begin
        taken = 1'b1;
      end
      brIfZero: begin
        taken = opndZero;
      end
      brIfNonzero: begin
        taken = !opndZero;
      end
      brRegister: begin
        taken  = 1'b1;
        target = opnd1_i;
      end
      default: begin
      end
    endcase
  end

  // No redirect from a delay slot or an instruction that must retry
  assign jump_o       = taken && !inDelaySlot_i && !stall_i;
  assign jumpTarget_o = jump_o ? target : '0;

endmodule

//--- verilog/operandBypass.sv
`timescale 1ns/1ns

module operandBypass (
  input  logic                rdEn_i,
  input  decodePkg::regAddr_t rdAddr_i,
  input  decodePkg::word_t    fileData_i,
  input  logic                exWrEn_i,
  input  decodePkg::regAddr_t exWrAddr_i,
  input  decodePkg::word_t    exWrData_i,
  input  decodePkg::aluOp_t   exAluOp_i,
  input  logic                memWrEn_i,
  input  decodePkg::regAddr_t memWrAddr_i,
  input  decodePkg::word_t    memWrData_i,
  output decodePkg::word_t    data_o,
  output logic                loadHazard_o
);
  import decodePkg::*;

  logic exHit;
  logic memHit;

  assign exHit  = (exWrAddr_i == rdAddr_i);
  assign memHit = memWrEn_i && (memWrAddr_i == rdAddr_i);

  always_comb begin
    loadHazard_o = 1'b0;
    if (!rdEn_i) begin
      data_o = '0;
    end else if (exHit && exAluOp_i == aluLw) begin
      // Load result not ready until after memory
      loadHazard_o = 1'b1;
      data_o       = '0;
    end else if (exHit && exWrEn_i) begin
      data_o = exWrData_i;
    end else if (memHit) begin
      data_o = memWrData_i;
    end else begin
      data_o = fileData_i;
    end
  end

endmodule

//--- verilog/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder (
  input  decodePkg::word_t       inst_i,
  output logic                   rd1En_o,
  output logic                   rd2En_o,
  output decodePkg::regAddr_t    rd1Addr_o,
  output decodePkg::regAddr_t    rd2Addr_o,
  output decodePkg::opnd1Src_t   opnd1Src_o,
  output decodePkg::opnd2Src_t   opnd2Src_o,
  output decodePkg::word_t       imm_o,
  output decodePkg::aluOp_t      aluOp_o,
  output logic                   wrEn_o,
  output decodePkg::regAddr_t    wrAddr_o,
  output decodePkg::branchKind_t branch_o
);
  import decodePkg::*;

  opcode_t  opcode;
  regAddr_t rx;
  regAddr_t ry;
  regAddr_t rz;
  word_t    sgnImm4;
  word_t    sgnImm5;
  word_t    sgnImm8;
  word_t    sgnImm11;
  word_t    shamt;

  assign opcode = opcode_t'(inst_i[15:11]);

  // Register fields, general registers only
  assign rx = {1'b0, inst_i[10:8]};
  assign ry = {1'b0, inst_i[7:5]};
  assign rz = {1'b0, inst_i[4:2]};

  assign sgnImm4  = {{12{inst_i[3]}}, inst_i[3:0]};
  assign sgnImm5  = {{11{inst_i[4]}}, inst_i[4:0]};
  assign sgnImm8  = {{8{inst_i[7]}}, inst_i[7:0]};
  assign sgnImm11 = {{5{inst_i[10]}}, inst_i[10:0]};
  assign shamt    = {13'b0, inst_i[4:2]};

  always_comb begin
    // Anything not matched below stays a NOP
    rd1En_o    = 1'b0;
    rd2En_o    = 1'b0;
    rd1Addr_o  = '0;
    rd2Addr_o  = '0;
    opnd1Src_o = src1Zero;
    opnd2Src_o = src2Zero;
    imm_o      = '0;
    aluOp_o    = aluNop;
    wrEn_o     = 1'b0;
    wrAddr_o   = '0;
    branch_o   = brNone;

    case (opcode)
      opB: begin
        imm_o    = sgnImm11;
        branch_o = brAlways;
      end
      opBeqz, opBnez: begin
        rd1En_o   = 1'b1;
        rd1Addr_o = rx;
        imm_o     = sgnImm8;
        branch_o  = (opcode == opBeqz) ? brIfZero : brIfNonzero;
      end
      opShift: begin
        if (inst_i[1:0] == functSll || inst_i[1:0] == functSra) begin
          rd1En_o    = 1'b1;
          rd1Addr_o  = ry;
          opnd1Src_o = src1Port;
          opnd2Src_o = src2Imm;
          imm_o      = shamt;
          aluOp_o    = (inst_i[1:0] == functSll) ? aluSll : aluSra;
          wrEn_o     = 1'b1;
          wrAddr_o   = rx;
        end
      end
      opAddiu3, opAddiu, opSlti, opCmpi, opLw: begin
        rd1En_o    = 1'b1;
        rd1Addr_o  = rx;
        opnd1Src_o = src1Port;
        opnd2Src_o = src2Imm;
        wrEn_o     = 1'b1;
        case (opcode)
          opAddiu3: begin
            imm_o    = sgnImm4;
            aluOp_o  = aluAdd;
            wrAddr_o = ry;
          end
          opAddiu: begin
            imm_o    = sgnImm8;
            aluOp_o  = aluAdd;
            wrAddr_o = rx;
          end
          opLw: begin
            imm_o    = sgnImm5;
            aluOp_o  = aluLw;
            wrAddr_o = ry;
          end
          default: begin
            // SLTI and CMPI both set T
            imm_o    = sgnImm8;
            aluOp_o  = (opcode == opSlti) ? aluSlt : aluCmp;
            wrAddr_o = regT;
          end
        endcase
      end
      opSpGroup: begin
        case (inst_i[10:8])
          functBteqz: begin
            rd1En_o   = 1'b1;
            rd1Addr_o = regT;
            imm_o     = sgnImm8;
            branch_o  = brIfZero;
          end
          functMtsp: begin
            rd1En_o    = 1'b1;
            rd1Addr_o  = ry;
            opnd1Src_o = src1Port;
            aluOp_o    = aluOr;
            wrEn_o     = 1'b1;
            wrAddr_o   = regSp;
          end
          functAddsp: begin
            rd1En_o    = 1'b1;
            rd1Addr_o  = regSp;
            opnd1Src_o = src1Port;
            opnd2Src_o = src2Imm;
            imm_o      = sgnImm8;
            aluOp_o    = aluAdd;
            wrEn_o     = 1'b1;
            wrAddr_o   = regSp;
          end
          default: begin
          end
        endcase
      end
      opLi: begin
        opnd1Src_o = src1ZeroImm8;
        imm_o      = sgnImm8;
        aluOp_o    = aluOr;
        wrEn_o     = 1'b1;
        wrAddr_o   = rx;
      end
      opLwSp: begin
        rd1En_o    = 1'b1;
        rd1Addr_o  = regSp;
        opnd1Src_o = src1Port;
        opnd2Src_o = src2Imm;
        imm_o      = sgnImm8;
        aluOp_o    = aluLw;
        wrEn_o     = 1'b1;
        wrAddr_o   = rx;
      end
      opSw, opSwSp: begin
        // Port 1 is the base, port 2 the store data
        rd1En_o    = 1'b1;
        rd2En_o    = 1'b1;
        rd1Addr_o  = (opcode == opSw) ? rx : regSp;
        rd2Addr_o  = (opcode == opSw) ? ry : rx;
        opnd1Src_o = src1PortImm;
        opnd2Src_o = src2Port;
        imm_o      = (opcode == opSw) ? sgnImm5 : sgnImm8;
        aluOp_o    = aluSw;
      end
      opAddSub: begin
        if (inst_i[1:0] == functAddu || inst_i[1:0] == functSubu) begin
          rd1En_o    = 1'b1;
          rd2En_o    = 1'b1;
          rd1Addr_o  = rx;
          rd2Addr_o  = ry;
          opnd1Src_o = src1Port;
          opnd2Src_o = src2Port;
          aluOp_o    = (inst_i[1:0] == functAddu) ? aluAdd : aluSub;
          wrEn_o     = 1'b1;
          wrAddr_o   = rz;
        end
      end
      opLogicJump: begin
        case (inst_i[4:0])
          functAnd, functOr: begin
            rd1En_o    = 1'b1;
            rd2En_o    = 1'b1;
            rd1Addr_o  = rx;
            rd2Addr_o  = ry;
            opnd1Src_o = src1Port;
            opnd2Src_o = src2Port;
            aluOp_o    = (inst_i[4:0] == functAnd) ? aluAnd : aluOr;
            wrEn_o     = 1'b1;
            wrAddr_o   = rx;
          end
          functNot: begin
            rd1En_o    = 1'b1;
            rd1Addr_o  = ry;
            opnd1Src_o = src1Port;
            aluOp_o    = aluNot;
            wrEn_o     = 1'b1;
            wrAddr_o   = rx;
          end
          default: begin
            // Jumps and MFPC have zero in bits 4 to 0
            case (inst_i[7:0])
              functJr, functJalr: begin
                rd1En_o   = 1'b1;
                rd1Addr_o = rx;
                branch_o  = brRegister;
                if (inst_i[7:0] == functJalr) begin
                  opnd1Src_o = src1InstAddr;
                  opnd2Src_o = src2PcStep;
                  aluOp_o    = aluAdd;
                  wrEn_o     = 1'b1;
                  wrAddr_o   = regRa;
                end
              end
              functMfpc: begin
                opnd1Src_o = src1InstAddr;
                aluOp_o    = aluOr;
                wrEn_o     = 1'b1;
                wrAddr_o   = rx;
              end
              default: begin
                if (inst_i[10:0] == functJrra) begin
                  rd1En_o   = 1'b1;
                  rd1Addr_o = regRa;
                  branch_o  = brRegister;
                end
              end
            endcase
          end
        endcase
      end
      default: begin
      end
    endcase
  end

endmodule

//--- verilog/decodePkg.sv
package decodePkg;

  // Datapath widths
  localparam int wordWidth    = 16;
  localparam int regAddrWidth = 4;

  typedef logic [wordWidth-1:0]    word_t;
  typedef logic [regAddrWidth-1:0] regAddr_t;

  // Registers outside the eight general ones
  localparam regAddr_t regT  = 4'd8;
  localparam regAddr_t regSp = 4'd9;
  localparam regAddr_t regRa = 4'd10;

  // Link offset past the delay slot
  localparam word_t pcStep = 16'd1;

  typedef enum logic [3:0] {
    aluNop = 4'd0,
    aluAdd = 4'd1,
    aluSub = 4'd2,
    aluAnd = 4'd3,
    aluOr  = 4'd4,
    aluNot = 4'd5,
    aluSll = 4'd6,
    aluSra = 4'd7,
    aluSlt = 4'd8,
    aluCmp = 4'd9,
    aluLw  = 4'd10,
    aluSw  = 4'd11
  } aluOp_t;

  // Major opcodes, bits 15 to 11
  typedef enum logic [4:0] {
    opNop       = 5'b00001,
    opB         = 5'b00010,
    opBeqz      = 5'b00100,
    opBnez      = 5'b00101,
    opShift     = 5'b00110,
    opAddiu3    = 5'b01000,
    opAddiu     = 5'b01001,
    opSlti      = 5'b01010,
    opSpGroup   = 5'b01100,
    opLi        = 5'b01101,
    opCmpi      = 5'b01110,
    opLwSp      = 5'b10010,
    opLw        = 5'b10011,
    opSwSp      = 5'b11010,
    opSw        = 5'b11011,
    opAddSub    = 5'b11100,
    opLogicJump = 5'b11101
  } opcode_t;

  // Bits 10 to 8 of the SP group
  localparam logic [2:0] functBteqz = 3'b000;
  localparam logic [2:0] functAddsp = 3'b011;
  localparam logic [2:0] functMtsp  = 3'b100;

  // Bits 1 to 0 of shift and add/sub
  localparam logic [1:0] functSll  = 2'b00;
  localparam logic [1:0] functSra  = 2'b11;
  localparam logic [1:0] functAddu = 2'b01;
  localparam logic [1:0] functSubu = 2'b11;

  // Logic/jump group, by field width
  localparam logic [4:0]  functAnd  = 5'b01100;
  localparam logic [4:0]  functOr   = 5'b01101;
  localparam logic [4:0]  functNot  = 5'b01111;
  localparam logic [7:0]  functJr   = 8'b0000_0000;
  localparam logic [7:0]  functMfpc = 8'b0100_0000;
  localparam logic [7:0]  functJalr = 8'b1100_0000;
  localparam logic [10:0] functJrra = 11'b000_0010_0000;

  typedef enum logic [2:0] {
    src1Zero, src1Port, src1ZeroImm8, src1InstAddr, src1PortImm
  } opnd1Src_t;

  typedef enum logic [1:0] {
    src2Zero, src2Port, src2Imm, src2PcStep
  } opnd2Src_t;

  typedef enum logic [2:0] {
    brNone, brAlways, brIfZero, brIfNonzero, brRegister
  } branchKind_t;

endpackage
